// ==== vlog.f ====
hdl/noc_pkg.sv
hdl/input_fifo.sv
hdl/route_select.sv
hdl/output_arbiter.sv
hdl/xy_router.sv
tb/tb_xy_router.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the XY router testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_xy_router \
  -Mdir obj_dir \
  -f vlog.f

./obj_dir/Vtb_xy_router | tee sim.log

if grep -q "Test failed" sim.log; then
  echo "Simulation reported a failure, see sim.log"
  exit 1
fi
echo "Simulation finished without failures"
exit 0

// ==== tb/tb_xy_router.sv ====
// Testbench for the five-port XY mesh router
// Random wormhole packets on all inputs, random output back-pressure,
// reference model with per source and output queues, and a watchdog

`timescale 1ns/1ps

module tb_xy_router;

  import noc_pkg::*;

  localparam int DataWidth = 32;
  localparam int NumPkts   = 40;
  localparam int MaxLen    = 4;
  localparam int SeqWidth  = 13;
  localparam int RandWidth = DataWidth - PortIdxWidth - SeqWidth;
  localparam int FlitW     = IdWidth + 1 + DataWidth;
  // Router sits at x 1, y 2 of a 4x4 mesh
  localparam int NodeX = 1;
  localparam int NodeY = 2;
  localparam logic [IdWidth-1:0] NodeId = IdWidth'((NodeY << XWidth) | NodeX);

  logic                                  clk   = 1'b0;
  logic                                  rst_n = 1'b0;
  noc_id_u                               xy_id = NodeId;
  logic    [NumPorts-1:0]                in_valid  = '0;
  logic    [NumPorts-1:0]                in_ready;
  noc_id_u [NumPorts-1:0]                in_dst    = '0;
  logic    [NumPorts-1:0]                in_last   = '0;
  logic    [NumPorts-1:0][DataWidth-1:0] in_data   = '0;
  logic    [NumPorts-1:0]                out_valid;
  logic    [NumPorts-1:0]                out_ready = '0;
  noc_id_u [NumPorts-1:0]                out_dst;
  logic    [NumPorts-1:0]                out_last;
  logic    [NumPorts-1:0][DataWidth-1:0] out_data;

  // Stimulus state
  int   seed = 60;
  logic stim_on  = 1'b0;
  logic gen_done = 1'b0;
  int   total_flits = 0;
  int   pkt_len  [NumPorts][NumPkts];
  int   pkt_idx  [NumPorts] = '{default: 0};
  int   flit_idx [NumPorts] = '{default: 0};
  int   seq      [NumPorts] = '{default: 0};

  // Reference model state, indexed [source][output]
  logic [FlitW-1:0] exp_q [NumPorts][NumPorts][$];
  logic [NumPorts-1:0] accepted = '0;
  logic [NumPorts-1:0] in_body  = '0;
  logic [NumPorts-1:0] in_pkt   = '0;
  int   head_route [NumPorts] = '{default: 0};
  int   cur_src    [NumPorts] = '{default: 0};
  int   flits_in  = 0;
  int   flits_out = 0;

  int reset_errors = 0;
  int flit_errors  = 0;
  int drain_errors = 0;

  xy_router #(
    .DataWidth (DataWidth)
  ) u_dut (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .xy_id_i     (xy_id),
    .in_valid_i  (in_valid),
    .in_ready_o  (in_ready),
    .in_dst_i    (in_dst),
    .in_last_i   (in_last),
    .in_data_i   (in_data),
    .out_valid_o (out_valid),
    .out_ready_i (out_ready),
    .out_dst_o   (out_dst),
    .out_last_o  (out_last),
    .out_data_o  (out_data)
  );

  always #5 clk = ~clk;

  // Dimension-ordered routing for a head destination
  function automatic int xy_route(logic [IdWidth-1:0] dst);
    int dx;
    int dy;
    dx = int'(dst[XWidth-1:0]);
    dy = int'(dst[IdWidth-1:XWidth]);
    if (dst == NodeId) begin
      return int'(PortEject);
    end
    if (dx == NodeX) begin
      return (dy < NodeY) ? int'(PortSouth) : int'(PortNorth);
    end
    return (dx < NodeX) ? int'(PortWest) : int'(PortEast);
  endfunction

  task automatic plan_packets();
    for (int p = 0; p < NumPorts; p++) begin
      for (int k = 0; k < NumPkts; k++) begin
        pkt_len[p][k] = 1 + int'({$random(seed)} % MaxLen);
        total_flits += pkt_len[p][k];
      end
    end
    gen_done = 1'b1;
  endtask

  // Advance past accepted flits, offer new ones, pick output readys
  task automatic drive_cycle();
    for (int p = 0; p < NumPorts; p++) begin
      if (accepted[p]) begin
        in_valid[p] = 1'b0;
        if (in_last[p]) begin
          pkt_idx[p]++;
          flit_idx[p] = 0;
        end else begin
          flit_idx[p]++;
        end
      end
      // About one cycle in four stays idle
      if (!in_valid[p] && pkt_idx[p] < NumPkts && ({$random(seed)} % 4) != 0) begin
        in_valid[p]     = 1'b1;
        in_dst[p].flat  = IdWidth'($random(seed));
        in_last[p]      = (flit_idx[p] == pkt_len[p][pkt_idx[p]] - 1);
        in_data[p]      = {PortIdxWidth'(p), SeqWidth'(seq[p]), RandWidth'($random(seed))};
        seq[p]++;
      end
    end
    for (int o = 0; o < NumPorts; o++) begin
      out_ready[o] = ({$random(seed)} % 10) < 7;
    end
  endtask

  // Queue every accepted flit under the route of its packet head
  task automatic record_inputs();
    for (int p = 0; p < NumPorts; p++) begin
      accepted[p] = in_valid[p] && in_ready[p];
      if (accepted[p]) begin
        if (!in_body[p]) begin
          head_route[p] = xy_route(in_dst[p].flat);
        end
        exp_q[p][head_route[p]].push_back({in_dst[p].flat, in_last[p], in_data[p]});
        in_body[p] = !in_last[p];
        flits_in++;
      end
    end
  endtask

  task automatic check_outputs();
    logic [FlitW-1:0] got;
    logic [FlitW-1:0] exp_flit;
    int src;
    for (int o = 0; o < NumPorts; o++) begin
      if (out_valid[o] && out_ready[o]) begin
        flits_out++;
        got = {out_dst[o].flat, out_last[o], out_data[o]};
        src = int'(out_data[o][DataWidth-1 -: PortIdxWidth]);
        assert (src < int'(NumPorts) && exp_q[src][o].size() > 0) else begin
          flit_errors++;
          $display("Output %0d sent a flit from source %0d that was never expected", o, src);
        end
        if (src < int'(NumPorts) && exp_q[src][o].size() > 0) begin
          exp_flit = exp_q[src][o].pop_front();
          assert (got == exp_flit) else begin
            flit_errors++;
            $write("Mismatch xy_route_flit out %0d src %0d: expected dst=%h last=%b data=%h, ",
                   o, src, exp_flit[FlitW-1 -: IdWidth], exp_flit[DataWidth],
                   exp_flit[DataWidth-1:0]);
            $display("actual dst=%h last=%b data=%h",
                     got[FlitW-1 -: IdWidth], got[DataWidth], got[DataWidth-1:0]);
          end
        end
        // A packet owns its output until the last flit
        if (in_pkt[o]) begin
          assert (src == cur_src[o]) else begin
            flit_errors++;
            $display("Output %0d put a flit from source %0d inside a packet from source %0d",
                     o, src, cur_src[o]);
          end
        end
        cur_src[o] = src;
        in_pkt[o]  = !out_last[o];
      end
    end
  endtask

  task automatic check_reset();
    for (int o = 0; o < NumPorts; o++) begin
      assert (!out_valid[o] && in_ready[o]) else begin
        reset_errors++;
        $write("Mismatch reset_state port %0d: expected out_valid=0 in_ready=1, ", o);
        $display("actual out_valid=%b in_ready=%b", out_valid[o], in_ready[o]);
      end
    end
  endtask

  task automatic check_drained();
    for (int s = 0; s < NumPorts; s++) begin
      for (int o = 0; o < NumPorts; o++) begin
        assert (exp_q[s][o].size() == 0) else begin
          drain_errors++;
          $display("Source %0d still has %0d flits that never left on output %0d",
                   s, exp_q[s][o].size(), o);
        end
      end
    end
  endtask

  always @(posedge clk) begin
    #1;
    if (stim_on) begin
      if (!gen_done) begin
        plan_packets();
      end
      drive_cycle();
    end
  end

  // Outputs and handshakes are stable at the falling edge
  always @(negedge clk) begin
    if (rst_n) begin
      check_outputs();
      record_inputs();
    end
  end

  initial begin
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check_reset();
    stim_on = 1'b1;
    wait (gen_done);
    while (flits_out < total_flits) begin
      @(negedge clk);
    end
    // Extra cycles expose duplicated flits
    repeat (20) @(posedge clk);
    check_drained();
    $display("Errors: reset %0d, flit %0d, drain %0d (flits sent %0d, received %0d)",
             reset_errors, flit_errors, drain_errors, flits_in, flits_out);
    if (reset_errors + flit_errors + drain_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    wait (gen_done);
    repeat (total_flits * 40 + 1000) @(posedge clk);
    $display("Timeout: only %0d of %0d flits left the router", flits_out, total_flits);
    $display("Test failed");
    $finish;
  end

endmodule

// ==== hdl/xy_router.sv ====
// Five-port XY mesh router, top level
// Input buffers, route selection and per-output arbitration

`timescale 1ns/1ps

module xy_router #(
  parameter int unsigned DataWidth = 32,
  parameter int unsigned FifoDepth = 4
) (
  input  logic                                                    clk_i,
  input  logic                                                    rst_n_i,
  input  noc_pkg::noc_id_u                                        xy_id_i,
  // Input links
  input  logic             [noc_pkg::NumPorts-1:0]                in_valid_i,
  output logic             [noc_pkg::NumPorts-1:0]                in_ready_o,
  input  noc_pkg::noc_id_u [noc_pkg::NumPorts-1:0]                in_dst_i,
  input  logic             [noc_pkg::NumPorts-1:0]                in_last_i,
  input  logic             [noc_pkg::NumPorts-1:0][DataWidth-1:0] in_data_i,
  // Output links
  output logic             [noc_pkg::NumPorts-1:0]                out_valid_o,
  input  logic             [noc_pkg::NumPorts-1:0]                out_ready_i,
  output noc_pkg::noc_id_u [noc_pkg::NumPorts-1:0]                out_dst_o,
  output logic             [noc_pkg::NumPorts-1:0]                out_last_o,
  output logic             [noc_pkg::NumPorts-1:0][DataWidth-1:0] out_data_o
);

  import noc_pkg::*;

  // Buffer heads
  logic    [NumPorts-1:0]                fifo_valid;
  noc_id_u [NumPorts-1:0]                fifo_dst;
  logic    [NumPorts-1:0]                fifo_last;
  logic    [NumPorts-1:0][DataWidth-1:0] fifo_data;

  // Flits after route selection
  logic    [NumPorts-1:0]                   rs_valid;
  noc_id_u [NumPorts-1:0]                   rs_dst;
  logic    [NumPorts-1:0]                   rs_last;
  logic    [NumPorts-1:0][DataWidth-1:0]    rs_data;
  logic    [NumPorts-1:0][PortIdxWidth-1:0] route;

  // Indexed [output][input]
  logic [NumPorts-1:0][NumPorts-1:0] req;
  logic [NumPorts-1:0][NumPorts-1:0] gnt;
  logic [NumPorts-1:0]               pop;

  for (genvar p = 0; p < NumPorts; p++) begin : gen_input
    input_fifo #(
      .DataWidth (DataWidth),
      .FifoDepth (FifoDepth)
    ) u_fifo (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .valid_i (in_valid_i[p]),
      .ready_o (in_ready_o[p]),
      .dst_i   (in_dst_i[p]),
      .last_i  (in_last_i[p]),
      .data_i  (in_data_i[p]),
      .valid_o (fifo_valid[p]),
      .ready_i (pop[p]),
      .dst_o   (fifo_dst[p]),
      .last_o  (fifo_last[p]),
      .data_o  (fifo_data[p])
    );

    route_select #(
      .DataWidth (DataWidth)
    ) u_route (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .xy_id_i (xy_id_i),
      .valid_i (fifo_valid[p]),
      .ready_i (pop[p]),
      .dst_i   (fifo_dst[p]),
      .last_i  (fifo_last[p]),
      .data_i  (fifo_data[p]),
      .valid_o (rs_valid[p]),
      .dst_o   (rs_dst[p]),
      .last_o  (rs_last[p]),
      .data_o  (rs_data[p]),
      .route_o (route[p])
    );
  end

  // An input requests the one output its route points at
  always_comb begin : proc_req
    for (int o = 0; o < NumPorts; o++) begin
      for (int p = 0; p < NumPorts; p++) begin
        req[o][p] = rs_valid[p] && (route[p] == PortIdxWidth'(o));
      end
    end
  end

  // At most one arbiter grants a given input
  always_comb begin : proc_pop
    pop = '0;
    for (int o = 0; o < NumPorts; o++) begin
      pop = pop | gnt[o];
    end
  end

  for (genvar o = 0; o < NumPorts; o++) begin : gen_output
    output_arbiter #(
      .DataWidth (DataWidth)
    ) u_arb (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .req_i   (req[o]),
      .dst_i   (rs_dst),
      .last_i  (rs_last),
      .data_i  (rs_data),
      .gnt_o   (gnt[o]),
      .valid_o (out_valid_o[o]),
      .ready_i (out_ready_i[o]),
      .dst_o   (out_dst_o[o]),
      .last_o  (out_last_o[o]),
      .data_o  (out_data_o[o])
    );
  end

endmodule

// ==== hdl/output_arbiter.sv ====
// Round-robin wormhole arbiter for one output port
// Packet lock, priority pointer and output flit multiplexer

`timescale 1ns/1ps

module output_arbiter #(
  parameter int unsigned DataWidth = 32
) (
  input  logic                                          clk_i,
  input  logic                                          rst_n_i,
  // Requests and flits from all inputs
  input  logic             [noc_pkg::NumPorts-1:0]                req_i,
  input  noc_pkg::noc_id_u [noc_pkg::NumPorts-1:0]                dst_i,
  input  logic             [noc_pkg::NumPorts-1:0]                last_i,
  input  logic             [noc_pkg::NumPorts-1:0][DataWidth-1:0] data_i,
  output logic             [noc_pkg::NumPorts-1:0]                gnt_o,
  // Output link
  output logic                                          valid_o,
  input  logic                                          ready_i,
  output noc_pkg::noc_id_u                              dst_o,
  output logic                                          last_o,
  output logic [DataWidth-1:0]                          data_o
);

  import noc_pkg::*;

  logic [PortIdxWidth-1:0] ptr_q;
  logic [PortIdxWidth-1:0] lock_idx_q;
  logic                    lock_q;
  logic [PortIdxWidth-1:0] pick_idx, sel_idx;
  logic                    pick_valid;

  // First requester at or after the priority pointer
  always_comb begin : proc_pick
    int unsigned idx;
    pick_valid = 1'b0;
    pick_idx   = '0;
    for (int unsigned i = 0; i < NumPorts; i++) begin
      idx = ptr_q + i;
      if (idx >= NumPorts) begin
        idx = idx - NumPorts;
      end
      if (!pick_valid && req_i[idx]) begin
        pick_valid = 1'b1;
        pick_idx   = PortIdxWidth'(idx);
      end
    end
  end

  assign sel_idx = lock_q ? lock_idx_q : pick_idx;
  // While locked, a packet with a gap in its flits just idles the output
  assign valid_o = lock_q ? req_i[lock_idx_q] : pick_valid;

  assign dst_o  = dst_i[sel_idx];
  assign last_o = last_i[sel_idx];
  assign data_o = data_i[sel_idx];

  always_comb begin : proc_gnt
    gnt_o = '0;
    gnt_o[sel_idx] = valid_o && ready_i;
  end

  // Lock on a stalled or partly sent packet; release after its last flit
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
      ptr_q      <= '0;
    end else if (valid_o) begin
      if (ready_i && last_o) begin
        lock_q <= 1'b0;
        ptr_q  <= (sel_idx == PortIdxWidth'(NumPorts - 1)) ? '0 : sel_idx + 1'b1;
      end else begin
        lock_q     <= 1'b1;
        lock_idx_q <= sel_idx;
      end
    end
  end

endmodule

// ==== hdl/route_select.sv ====
// XY route computation for one input port
// Head flit picks the port, later flits of the packet reuse it

`timescale 1ns/1ps

module route_select #(
  parameter int unsigned DataWidth = 32
) (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  noc_pkg::noc_id_u                  xy_id_i,
  // Flit from the input buffer
  input  logic                              valid_i,
  input  logic                              ready_i,
  input  noc_pkg::noc_id_u                  dst_i,
  input  logic                              last_i,
  input  logic [DataWidth-1:0]              data_i,
  // Flit towards the arbiters
  output logic                              valid_o,
  output noc_pkg::noc_id_u                  dst_o,
  output logic                              last_o,
  output logic [DataWidth-1:0]              data_o,
  output logic [noc_pkg::PortIdxWidth-1:0]  route_o
);

  import noc_pkg::*;

  logic [PortIdxWidth-1:0] route_d, route_q;
  logic                    lock_q;

  // Flit passes through untouched
  assign valid_o = valid_i;
  assign dst_o   = dst_i;
  assign last_o  = last_i;
  assign data_o  = data_i;

  // Dimension-ordered routing, X first then Y
  always_comb begin : proc_route
    if (dst_i.flat == xy_id_i.flat) begin
      route_d = PortEject;
    end else if (dst_i.xy.x == xy_id_i.xy.x) begin
      if (dst_i.xy.y < xy_id_i.xy.y) begin
        route_d = PortSouth;
      end else begin
        route_d = PortNorth;
      end
    end else begin
      if (dst_i.xy.x < xy_id_i.xy.x) begin
        route_d = PortWest;
      end else begin
        route_d = PortEast;
      end
    end
  end

  // Body flits carry no valid destination, so follow the stored route
  assign route_o = lock_q ? route_q : route_d;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      lock_q  <= 1'b0;
      route_q <= '0;
    end else if (valid_i && ready_i) begin
      // Capture only on the first flit of a packet
      if (!lock_q) begin
        route_q <= route_d;
      end
      lock_q <= ~last_i;
    end
  end

endmodule

// ==== hdl/input_fifo.sv ====
// Input port flit buffer
// Circular buffer with valid/ready handshakes on both sides

`timescale 1ns/1ps

module input_fifo #(
  parameter int unsigned DataWidth = 32,
  parameter int unsigned FifoDepth = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  // Write side
  input  logic                 valid_i,
  output logic                 ready_o,
  input  noc_pkg::noc_id_u     dst_i,
  input  logic                 last_i,
  input  logic [DataWidth-1:0] data_i,
  // Read side, head of the buffer
  output logic                 valid_o,
  input  logic                 ready_i,
  output noc_pkg::noc_id_u     dst_o,
  output logic                 last_o,
  output logic [DataWidth-1:0] data_o
);

  import noc_pkg::*;

  localparam int unsigned PtrWidth = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam int unsigned CntWidth = $clog2(FifoDepth + 1);

  noc_id_u              dst_mem  [FifoDepth];
  logic                 last_mem [FifoDepth];
  logic [DataWidth-1:0] data_mem [FifoDepth];

  logic [PtrWidth-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                full, push, pop;

  assign full    = (count_q == CntWidth'(FifoDepth));
  assign valid_o = (count_q != '0);
  // A full buffer still takes a flit when the head leaves in the same cycle
  assign ready_o = !full || ready_i;
  assign push    = valid_i && ready_o;
  assign pop     = valid_o && ready_i;

  assign dst_o  = dst_mem[rd_ptr_q];
  assign last_o = last_mem[rd_ptr_q];
  assign data_o = data_mem[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push) begin
      dst_mem[wr_ptr_q]  <= dst_i;
      last_mem[wr_ptr_q] <= last_i;
      data_mem[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(FifoDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(FifoDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Occupancy only moves when exactly one side transfers
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

endmodule

// ==== hdl/noc_pkg.sv ====
// Shared definitions for the XY mesh router
// Coordinate and ID widths, port indices and the node-ID union

package noc_pkg;

  // Mesh coordinate widths
  localparam int unsigned XWidth  = 2;
  localparam int unsigned YWidth  = 2;
  localparam int unsigned IdWidth = XWidth + YWidth;

  // Router ports
  localparam int unsigned NumPorts     = 5;
  localparam int unsigned PortIdxWidth = 3;

  // Port index meaning
  localparam logic [PortIdxWidth-1:0] PortEject = PortIdxWidth'(0);
  localparam logic [PortIdxWidth-1:0] PortSouth = PortIdxWidth'(1);
  localparam logic [PortIdxWidth-1:0] PortWest  = PortIdxWidth'(2);
  localparam logic [PortIdxWidth-1:0] PortNorth = PortIdxWidth'(3);
  localparam logic [PortIdxWidth-1:0] PortEast  = PortIdxWidth'(4);

  // Node ID, seen either as one number or as a coordinate pair
  typedef union packed {
    logic [IdWidth-1:0] flat;
    struct packed {
      logic [YWidth-1:0] y;
      logic [XWidth-1:0] x;
    } xy;
  } noc_id_u;

endpackage
